// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_uncore -f uncore.f -o tb_uncore
	@out="$$(obj_dir/tb_uncore)"; echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

// ==== axi_ram.sv ====
`timescale 1ns/1ps
`include "uncore_params.svh"

module axi_ram
    import uncore_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,

    input  logic  awvalid,
    output logic  awready,
    input  addr_t awaddr,

    input  logic  wvalid,
    output logic  wready,
    input  data_t wdata,
    input  strb_t wstrb,

    output logic  bvalid,
    input  logic  bready,

    input  logic  arvalid,
    output logic  arready,
    input  addr_t araddr,

    output logic  rvalid,
    input  logic  rready,
    output data_t rdata
);

    data_t      mem [`UNCORE_RAM_WORDS];
    ram_state_t state;
    ram_index_t windex;
    ram_index_t rindex;
    logic       write_req;
    logic       write_fire;
    logic       read_fire;

    // Upper address bits are dropped, so the array aliases.
    assign windex = awaddr[`UNCORE_RAM_INDEX_BITS+1:2];
    assign rindex = araddr[`UNCORE_RAM_INDEX_BITS+1:2];

    // Writes need address and data together and win over reads.
    assign write_req = awvalid && wvalid;
    assign awready   = (state == RAM_IDLE) && write_req;
    assign wready    = (state == RAM_IDLE) && write_req;
    assign arready   = (state == RAM_IDLE) && !write_req;

    assign write_fire = awvalid && awready && wvalid && wready;
    assign read_fire  = arvalid && arready;

    assign bvalid = (state == RAM_BRESP);
    assign rvalid = (state == RAM_RRESP);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= RAM_IDLE;
        end else begin
            case (state)
                RAM_IDLE: begin
                    if (write_fire)
                        state <= RAM_BRESP;
                    else if (read_fire)
                        state <= RAM_RRESP;
                end
                RAM_BRESP: begin
                    if (bready)
                        state <= RAM_IDLE;
                end
                RAM_RRESP: begin
                    if (rready)
                        state <= RAM_IDLE;
                end
                default: state <= RAM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (write_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i])
                    mem[windex][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        if (read_fire)
            rdata <= mem[rindex];
    end

    a_resp_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(bvalid && rvalid))
        else $error("bvalid and rvalid high together");

    // The master takes each response in the cycle it appears.
    a_resp_taken: assert property (@(posedge clk) disable iff (!resetn)
        !(bvalid && !bready) && !(rvalid && !rready))
        else $error("response not taken in its own cycle");

endmodule

// ==== console_port.sv ====
`timescale 1ns/1ps

module console_port
    import uncore_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  con_valid,
    input  data_t wdata,
    input  strb_t wstrb,
    output logic  con_ready,
    output logic  char_valid,
    output char_t char_data
);

    logic  ack;
    char_t char_q;

    // Set by a new request, dropped once it completes.
    always_ff @(posedge clk) begin
        if (!resetn)
            ack <= 1'b0;
        else if (con_valid && con_ready)
            ack <= 1'b0;
        else if (con_valid)
            ack <= 1'b1;
    end

    // Byte lane 0 carries the character.
    always_ff @(posedge clk) begin
        if (con_valid && !ack)
            char_q <= wdata[7:0] & {8{wstrb[0]}};
    end

    assign con_ready  = ack;
    assign char_valid = ack;
    assign char_data  = char_q;

    a_char_pulse: assert property (@(posedge clk) disable iff (!resetn)
        char_valid |=> !char_valid)
        else $error("char_valid held for two cycles");

endmodule

// ==== mem_axi_bridge.sv ====
`timescale 1ns/1ps

module mem_axi_bridge
    import uncore_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,

    input  logic  ram_valid,
    input  addr_t addr,
    input  data_t wdata,
    input  strb_t wstrb,
    output logic  ram_ready,
    output data_t ram_rdata,

    output logic  axi_awvalid,
    input  logic  axi_awready,
    output addr_t axi_awaddr,

    output logic  axi_wvalid,
    input  logic  axi_wready,
    output data_t axi_wdata,
    output strb_t axi_wstrb,

    input  logic  axi_bvalid,
    output logic  axi_bready,

    output logic  axi_arvalid,
    input  logic  axi_arready,
    output addr_t axi_araddr,

    input  logic  axi_rvalid,
    output logic  axi_rready,
    input  data_t axi_rdata
);

    logic is_write;
    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic ar_fire;
    logic r_fire;
    logic aw_done;
    logic w_done;
    logic ar_done;

    assign is_write = |wstrb;

    assign aw_fire = axi_awvalid && axi_awready;
    assign w_fire  = axi_wvalid && axi_wready;
    assign b_fire  = axi_bvalid && axi_bready;
    assign ar_fire = axi_arvalid && axi_arready;
    assign r_fire  = axi_rvalid && axi_rready;

    // Each channel stays quiet after its transfer until the response completes.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            ar_done <= 1'b0;
        end else begin
            if (b_fire)
                aw_done <= 1'b0;
            else if (aw_fire)
                aw_done <= 1'b1;

            if (b_fire)
                w_done <= 1'b0;
            else if (w_fire)
                w_done <= 1'b1;

            if (r_fire)
                ar_done <= 1'b0;
            else if (ar_fire)
                ar_done <= 1'b1;
        end
    end

    assign axi_awvalid = ram_valid && is_write && !aw_done;
    assign axi_awaddr  = addr;
    assign axi_wvalid  = ram_valid && is_write && !w_done;
    assign axi_wdata   = wdata;
    assign axi_wstrb   = wstrb;
    assign axi_bready  = aw_done && w_done;

    assign axi_arvalid = ram_valid && !is_write && !ar_done;
    assign axi_araddr  = addr;
    assign axi_rready  = ar_done;

    assign ram_ready = b_fire || r_fire;
    assign ram_rdata = axi_rdata;

    a_no_aw_ar_overlap: assert property (@(posedge clk) disable iff (!resetn)
        !(axi_awvalid && axi_arvalid))
        else $error("awvalid and arvalid high together");

    // RAM path turns around in one cycle.
    a_ram_latency: assert property (@(posedge clk) disable iff (!resetn)
        $rose(ram_valid) |=> ram_ready)
        else $error("RAM request not completed one cycle after valid");

endmodule

// ==== tb_uncore.sv ====
`timescale 1ns/1ps
`include "uncore_params.svh"

module tb_uncore;
    import uncore_pkg::*;

    logic  clk;
    logic  resetn;
    logic  mem_valid;
    addr_t mem_addr;
    data_t mem_wdata;
    strb_t mem_wstrb;
    logic  mem_ready;
    data_t mem_rdata;
    logic  char_valid;
    char_t char_data;
    logic  bus_error;

    // Stimulus and expected response, one queue per column.
    logic  tab_wr    [$];
    addr_t tab_addr  [$];
    data_t tab_wdata [$];
    strb_t tab_strb  [$];
    data_t tab_rdata [$];
    char_t tab_char  [$];
    logic  tab_con   [$];
    logic  tab_err   [$];

    // Reference image of the RAM contents.
    data_t image [`UNCORE_RAM_WORDS];

    logic [31:0] lfsr;
    int mismatches;
    int failures;
    int cycles = 0;
    int cycle_limit = 0;

    uncore_top uncore_top_inst (
        .clk        (clk),
        .resetn     (resetn),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_wstrb  (mem_wstrb),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .char_valid (char_valid),
        .char_data  (char_data),
        .bus_error  (bus_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken.
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    // Classifies the access and works out its response from the image.
    task automatic add_entry(input logic wr, input addr_t addr, input data_t wdata,
                             input strb_t strb);
        ram_index_t widx;
        logic is_ram;
        logic is_con;
        data_t rdata;
        char_t ch;
        is_ram = (addr[31:28] == 4'h0);
        is_con = wr && (addr == `UNCORE_CONSOLE_ADDR);
        widx = ram_index_t'((addr >> 2) % `UNCORE_RAM_WORDS);
        rdata = '0;
        ch = '0;
        if (is_ram && wr) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b])
                    image[widx][8*b +: 8] = wdata[8*b +: 8];
            end
        end else if (is_ram) begin
            rdata = image[widx];
        end else if (is_con) begin
            ch = strb[0] ? wdata[7:0] : 8'h00;
        end else begin
            rdata = `UNCORE_ERR_RDATA;
        end
        tab_wr.push_back(wr);
        tab_addr.push_back(addr);
        tab_wdata.push_back(wdata);
        tab_strb.push_back(wr ? strb : 4'h0);
        tab_rdata.push_back(rdata);
        tab_char.push_back(ch);
        tab_con.push_back(is_con);
        tab_err.push_back(!is_ram && !is_con);
    endtask

    task automatic build_table();
        logic [31:0] word;
        logic [31:0] hi_a;
        logic [31:0] hi_b;
        logic [31:0] data;
        for (int i = 0; i < `UNCORE_RAM_WORDS; i++)
            image[i] = '0;
        add_entry(1'b1, 32'h0000_0010, 32'hdead_beef, 4'hf);
        add_entry(1'b0, 32'h0000_0010, 32'h0, 4'h0);
        // Partial strobes over a known word.
        add_entry(1'b1, 32'h0000_0020, 32'h1122_3344, 4'hf);
        add_entry(1'b1, 32'h0000_0020, 32'haabb_ccdd, 4'b0101);
        add_entry(1'b0, 32'h0000_0020, 32'h0, 4'h0);
        add_entry(1'b1, 32'h0000_0020, 32'h9988_7766, 4'b1000);
        add_entry(1'b0, 32'h0000_0020, 32'h0, 4'h0);
        // Console writes.
        add_entry(1'b1, `UNCORE_CONSOLE_ADDR, 32'h0000_0041, 4'hf);
        add_entry(1'b1, `UNCORE_CONSOLE_ADDR, 32'h0000_5a42, 4'b0010);
        add_entry(1'b1, `UNCORE_CONSOLE_ADDR, 32'h0000_0063, 4'b0001);
        // Unmapped accesses and console reads.
        add_entry(1'b1, 32'h2000_0010, 32'h1234_5678, 4'hf);
        add_entry(1'b0, `UNCORE_CONSOLE_ADDR, 32'h0, 4'h0);
        add_entry(1'b0, 32'h8000_0010, 32'h0, 4'h0);
        add_entry(1'b1, 32'h1000_0004, 32'hcafe_f00d, 4'hf);
        add_entry(1'b0, 32'h0000_0010, 32'h0, 4'h0);
        // Aliases above the index bits.
        add_entry(1'b1, 32'h0000_1010, 32'h5555_aaaa, 4'hf);
        add_entry(1'b0, 32'h0000_0010, 32'h0, 4'h0);
        add_entry(1'b0, 32'h0fff_f010, 32'h0, 4'h0);
        for (int k = 0; k < 5; k++) begin
            word = lfsr_bits(10);
            hi_a = lfsr_bits(16);
            hi_b = lfsr_bits(16);
            data = lfsr_bits(32);
            add_entry(1'b1, {4'h0, hi_a[15:0], word[9:0], 2'b00}, data, 4'hf);
            add_entry(1'b0, {4'h0, hi_b[15:0], word[9:0], 2'b00}, 32'h0, 4'h0);
        end
    endtask

    task automatic apply_entry(input int idx);
        int waits;
        @(posedge clk);
        #1;
        mem_valid = 1'b1;
        mem_addr  = tab_addr[idx];
        mem_wdata = tab_wdata[idx];
        mem_wstrb = tab_strb[idx];
        waits = 0;
        // Count the cycles spent before mem_ready.
        do begin
            @(negedge clk);
            if (!mem_ready) begin
                waits++;
                if (char_valid || bus_error) begin
                    $display("entry %0d raised char_valid or bus_error before mem_ready",
                             idx);
                    failures++;
                end
            end
        end while (!mem_ready);
        if (waits != 1) begin
            $display("entry %0d completed after %0d cycles instead of one", idx, waits);
            failures++;
        end
        if (!tab_wr[idx] && mem_rdata !== tab_rdata[idx]) begin
            $display("mismatch entry %0d mem_rdata: got %h expected %h",
                     idx, mem_rdata, tab_rdata[idx]);
            mismatches++;
        end
        if (bus_error !== tab_err[idx]) begin
            $display("mismatch entry %0d bus_error: got %h expected %h",
                     idx, bus_error, tab_err[idx]);
            mismatches++;
        end
        if (char_valid !== tab_con[idx]) begin
            $display("mismatch entry %0d char_valid: got %h expected %h",
                     idx, char_valid, tab_con[idx]);
            mismatches++;
        end
        if (tab_con[idx] && char_data !== tab_char[idx]) begin
            $display("mismatch entry %0d char_data: got %h expected %h",
                     idx, char_data, tab_char[idx]);
            mismatches++;
        end
    endtask

    task automatic check_idle(input string when);
        if (mem_ready !== 1'b0 || char_valid !== 1'b0 || bus_error !== 1'b0) begin
            $display("outputs not idle %s", when);
            failures++;
        end
    endtask

    initial begin
        mismatches = 0;
        failures   = 0;
        lfsr       = 32'he1c6ba67;
        resetn     = 1'b0;
        mem_valid  = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        mem_wstrb  = '0;
        build_table();
        cycle_limit = 4 * tab_addr.size() + 50;

        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(negedge clk);
        check_idle("after reset");

        for (int i = 0; i < tab_addr.size(); i++)
            apply_entry(i);

        @(posedge clk);
        #1;
        mem_valid = 1'b0;
        mem_wstrb = '0;
        @(negedge clk);
        check_idle("after the last access");

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== uncore.f ====
+incdir+.
uncore_pkg.sv
mem_axi_bridge.sv
axi_ram.sv
console_port.sv
uncore_router.sv
uncore_top.sv
tb_uncore.sv

// ==== uncore_params.svh ====
`ifndef UNCORE_PARAMS_SVH
`define UNCORE_PARAMS_SVH

// RAM geometry in 32-bit words.
`define UNCORE_RAM_WORDS 1024

// Must stay log2 of the word count.
`define UNCORE_RAM_INDEX_BITS 10

// Top address nibble that selects the RAM region.
`define UNCORE_RAM_REGION 4'h0

// Byte address of the console output register.
`define UNCORE_CONSOLE_ADDR 32'h1000_0000

// Read data returned on a bus error.
`define UNCORE_ERR_RDATA 32'hffff_ffff

`endif

// ==== uncore_pkg.sv ====
`include "uncore_params.svh"

package uncore_pkg;

    // Byte address on the native port and the AXI-lite channels.
    typedef logic [31:0] addr_t;

    typedef logic [31:0] data_t;

    // Byte write enables, all zero for a read.
    typedef logic [3:0] strb_t;

    typedef logic [7:0] char_t;

    // Word index into the RAM array.
    typedef logic [`UNCORE_RAM_INDEX_BITS-1:0] ram_index_t;

    // Response engine of the RAM slave.
    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_BRESP,
        RAM_RRESP
    } ram_state_t;

endpackage

// ==== uncore_router.sv ====
`timescale 1ns/1ps
`include "uncore_params.svh"

module uncore_router
    import uncore_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,

    input  logic  mem_valid,
    input  addr_t mem_addr,
    input  data_t mem_wdata,
    input  strb_t mem_wstrb,
    output logic  mem_ready,
    output data_t mem_rdata,

    output addr_t addr,
    output data_t wdata,
    output strb_t wstrb,

    output logic  ram_valid,
    input  logic  ram_ready,
    input  data_t ram_rdata,

    output logic  con_valid,
    input  logic  con_ready,

    output logic  bus_error
);

    logic is_write;
    logic is_ram;
    logic is_con;
    logic is_unmapped;
    logic err_q;

    assign is_write    = |mem_wstrb;
    assign is_ram      = (mem_addr[31:28] == `UNCORE_RAM_REGION);
    // Console is write only.
    assign is_con      = is_write && (mem_addr == `UNCORE_CONSOLE_ADDR);
    assign is_unmapped = !is_ram && !is_con;

    assign ram_valid = mem_valid && is_ram;
    assign con_valid = mem_valid && is_con;

    assign addr  = mem_addr;
    assign wdata = mem_wdata;
    assign wstrb = mem_wstrb;

    // Unmapped access completes here after one cycle.
    always_ff @(posedge clk) begin
        if (!resetn)
            err_q <= 1'b0;
        else if (mem_valid && mem_ready)
            err_q <= 1'b0;
        else if (mem_valid && is_unmapped)
            err_q <= 1'b1;
    end

    assign mem_ready = ram_ready || con_ready || err_q;
    assign mem_rdata = err_q ? `UNCORE_ERR_RDATA : ram_rdata;
    assign bus_error = err_q;

    a_ready_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
        mem_ready |-> mem_valid)
        else $error("mem_ready without mem_valid");

    a_native_latency: assert property (@(posedge clk) disable iff (!resetn)
        $rose(mem_valid) |=> mem_ready)
        else $error("access not completed one cycle after mem_valid");

endmodule

// ==== uncore_top.sv ====
`timescale 1ns/1ps

module uncore_top
    import uncore_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  mem_valid,
    input  addr_t mem_addr,
    input  data_t mem_wdata,
    input  strb_t mem_wstrb,
    output logic  mem_ready,
    output data_t mem_rdata,
    output logic  char_valid,
    output char_t char_data,
    output logic  bus_error
);

    addr_t req_addr;
    data_t req_wdata;
    strb_t req_wstrb;

    logic  ram_valid;
    logic  ram_ready;
    data_t ram_rdata;
    logic  con_valid;
    logic  con_ready;

    logic  axi_awvalid;
    logic  axi_awready;
    addr_t axi_awaddr;
    logic  axi_wvalid;
    logic  axi_wready;
    data_t axi_wdata;
    strb_t axi_wstrb;
    logic  axi_bvalid;
    logic  axi_bready;
    logic  axi_arvalid;
    logic  axi_arready;
    addr_t axi_araddr;
    logic  axi_rvalid;
    logic  axi_rready;
    data_t axi_rdata;

    uncore_router router_inst (
        .clk       (clk),
        .resetn    (resetn),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .addr      (req_addr),
        .wdata     (req_wdata),
        .wstrb     (req_wstrb),
        .ram_valid (ram_valid),
        .ram_ready (ram_ready),
        .ram_rdata (ram_rdata),
        .con_valid (con_valid),
        .con_ready (con_ready),
        .bus_error (bus_error)
    );

    mem_axi_bridge bridge_inst (
        .clk         (clk),
        .resetn      (resetn),
        .ram_valid   (ram_valid),
        .addr        (req_addr),
        .wdata       (req_wdata),
        .wstrb       (req_wstrb),
        .ram_ready   (ram_ready),
        .ram_rdata   (ram_rdata),
        .axi_awvalid (axi_awvalid),
        .axi_awready (axi_awready),
        .axi_awaddr  (axi_awaddr),
        .axi_wvalid  (axi_wvalid),
        .axi_wready  (axi_wready),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_bvalid  (axi_bvalid),
        .axi_bready  (axi_bready),
        .axi_arvalid (axi_arvalid),
        .axi_arready (axi_arready),
        .axi_araddr  (axi_araddr),
        .axi_rvalid  (axi_rvalid),
        .axi_rready  (axi_rready),
        .axi_rdata   (axi_rdata)
    );

    axi_ram ram_inst (
        .clk     (clk),
        .resetn  (resetn),
        .awvalid (axi_awvalid),
        .awready (axi_awready),
        .awaddr  (axi_awaddr),
        .wvalid  (axi_wvalid),
        .wready  (axi_wready),
        .wdata   (axi_wdata),
        .wstrb   (axi_wstrb),
        .bvalid  (axi_bvalid),
        .bready  (axi_bready),
        .arvalid (axi_arvalid),
        .arready (axi_arready),
        .araddr  (axi_araddr),
        .rvalid  (axi_rvalid),
        .rready  (axi_rready),
        .rdata   (axi_rdata)
    );

    console_port console_inst (
        .clk        (clk),
        .resetn     (resetn),
        .con_valid  (con_valid),
        .wdata      (req_wdata),
        .wstrb      (req_wstrb),
        .con_ready  (con_ready),
        .char_valid (char_valid),
        .char_data  (char_data)
    );

endmodule
